// ==== hdl/fixflo_pkg.sv ====
// fixflo shared definitions
// widths, binary16 format constants, operation codes and the flag,
// decoded-operand and request structs used across the arithmetic unit

package fixflo_pkg;

  localparam int WORD_W     = 16;  // operand and result width
  localparam int FRAC_W     = 10;  // binary16 fraction
  localparam int FIX_FRAC_W = 8;   // 8.8 fixed point fraction
  localparam int EXP_W      = 5;
  localparam int EXP_BIAS   = 15;
  localparam int EXP_MAX    = 31;  // all-ones exponent
  localparam int SIG_W      = FRAC_W + 1;  // with hidden bit

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [EXP_W-1:0]  exp_t;
  typedef logic [SIG_W-1:0]  sig_t;

  localparam word_t QNAN = 16'h7E00;  // canonical quiet NaN

  typedef enum logic [1:0] {
    OP_FIX_ADD = 2'd0,
    OP_FIX_MUL = 2'd1,
    OP_FLT_MUL = 2'd2
  } op_e;

  typedef struct packed {
    logic overflow;
    logic zero;
    logic nan;
    logic precision_lost;
  } flags_t;

  // one binary16 operand split into fields
  typedef struct packed {
    logic sign;
    exp_t exp;
    sig_t sig;      // hidden bit in the msb
    logic is_zero;  // subnormals land here too
    logic is_inf;
    logic is_nan;
  } half_fields_t;

  typedef struct packed {
    op_e   op;
    word_t a;
    word_t b;
  } fix_req_t;

endpackage

// ==== hdl/fixed_multiplier.sv ====
// fixed_multiplier
// unsigned 8.8 fixed point multiply from sixteen gated partial products,
// flags integer overflow and dropped fraction bits

`timescale 1ns/1ns

module fixed_multiplier (
  input  fixflo_pkg::word_t  a,
  input  fixflo_pkg::word_t  b,
  output fixflo_pkg::word_t  result,
  output fixflo_pkg::flags_t flags
);
  import fixflo_pkg::*;

  logic [2*WORD_W-1:0] a_ext;
  logic [2*WORD_W-1:0] pp [WORD_W];  // shifted copies of a
  logic [2*WORD_W-1:0] grp [4];      // partial sums
  logic [2*WORD_W-1:0] prod;

  // a sits with its binary point at bit 16 of the wide word
  assign a_ext = {{(WORD_W-FIX_FRAC_W){1'b0}}, a, {FIX_FRAC_W{1'b0}}};

  // b[i] weighs 2^(i-8)
  always_comb
  begin
    for (int i = 0; i < WORD_W; i++)
    begin
      if (i < FIX_FRAC_W)
        pp[i] = (a_ext >> (FIX_FRAC_W - i)) & {(2*WORD_W){b[i]}};
      else
        pp[i] = (a_ext << (i - FIX_FRAC_W)) & {(2*WORD_W){b[i]}};
    end
  end

  // four interleaved groups, then one final add
  always_comb
  begin
    for (int g = 0; g < 4; g++)
    begin
      grp[g] = pp[g] + pp[g+4] + pp[g+8] + pp[g+12];
    end
  end

  assign prod = grp[0] + grp[1] + grp[2] + grp[3];

  // keep the middle 8.8 window
  assign result = prod[WORD_W+FIX_FRAC_W-1:FIX_FRAC_W];

  assign flags = '{
    overflow:       |prod[2*WORD_W-1:WORD_W+FIX_FRAC_W],  // integer part too wide
    zero:           1'b0,
    nan:            1'b0,
    precision_lost: |prod[FIX_FRAC_W-1:0]                 // truncated fraction
  };

endmodule

// ==== hdl/half_decoder.sv ====
// half_decoder
// splits a binary16 word into sign, exponent and significand and
// classifies it; subnormal inputs are treated as zero

`timescale 1ns/1ns

module half_decoder (
  input  fixflo_pkg::word_t        num,
  output fixflo_pkg::half_fields_t fields
);
  import fixflo_pkg::*;

  exp_t              exp_raw;
  logic [FRAC_W-1:0] frac;
  logic              exp_ones;

  assign exp_raw  = num[WORD_W-2 -: EXP_W];
  assign frac     = num[FRAC_W-1:0];
  assign exp_ones = (exp_raw == exp_t'(EXP_MAX));

  always_comb
  begin
    fields.sign    = num[WORD_W-1];
    fields.exp     = exp_raw;
    fields.sig     = {|exp_raw, frac};  // hidden bit for normals
    fields.is_zero = (exp_raw == '0);   // flush subnormals
    fields.is_inf  = exp_ones & (frac == '0);
    fields.is_nan  = exp_ones & (frac != '0);
  end

endmodule

// ==== hdl/half_multiplier.sv ====
// half_multiplier
// binary16 multiply of normal operands with truncation; handles NaN,
// infinity, zero, exponent overflow and underflow to signed zero

`timescale 1ns/1ns

module half_multiplier (
  input  fixflo_pkg::word_t  a,
  input  fixflo_pkg::word_t  b,
  output fixflo_pkg::word_t  result,
  output fixflo_pkg::flags_t flags
);
  import fixflo_pkg::*;

  half_fields_t        fa;
  half_fields_t        fb;
  logic                sign_r;
  logic [2*SIG_W-1:0]  prod;
  logic                norm;      // product in [2,4)
  logic [EXP_W+1:0]    exp_sum;   // two guard bits, read as signed
  logic [FRAC_W-1:0]   frac_r;
  logic                frac_lost;
  logic                nan_case;
  logic                inf_case;
  logic                zero_case;

  half_decoder u_dec_a (
    .num    (a),
    .fields (fa)
  );

  half_decoder u_dec_b (
    .num    (b),
    .fields (fb)
  );

  assign sign_r = fa.sign ^ fb.sign;
  assign prod   = fa.sig * fb.sig;
  assign norm   = prod[2*SIG_W-1];

  assign exp_sum = {2'b00, fa.exp} + {2'b00, fb.exp} + (EXP_W+2)'(norm)
                 - (EXP_W+2)'(EXP_BIAS);

  // drop the leading one, truncate the rest
  assign frac_r    = norm ? prod[2*SIG_W-2 -: FRAC_W] : prod[2*SIG_W-3 -: FRAC_W];
  assign frac_lost = norm ? |prod[SIG_W-1:0] : |prod[FRAC_W-1:0];

  assign nan_case  = fa.is_nan | fb.is_nan
                   | (fa.is_inf & fb.is_zero) | (fa.is_zero & fb.is_inf);
  assign inf_case  = fa.is_inf | fb.is_inf;
  assign zero_case = fa.is_zero | fb.is_zero;

  always_comb
  begin
    result = {sign_r, exp_sum[EXP_W-1:0], frac_r};
    flags  = '0;
    if (nan_case)
    begin
      result    = QNAN;
      flags.nan = 1'b1;
    end
    else if (inf_case)
    begin
      result         = {sign_r, exp_t'(EXP_MAX), {FRAC_W{1'b0}}};
      flags.overflow = 1'b1;
    end
    else if (zero_case)
    begin
      result     = {sign_r, {(WORD_W-1){1'b0}}};
      flags.zero = 1'b1;
    end
    else if ($signed(exp_sum) >= EXP_MAX)
    begin
      // too large for binary16
      result               = {sign_r, exp_t'(EXP_MAX), {FRAC_W{1'b0}}};
      flags.overflow       = 1'b1;
      flags.precision_lost = 1'b1;
    end
    else if ($signed(exp_sum) < 1)
    begin
      result               = {sign_r, {(WORD_W-1){1'b0}}};  // no subnormal output
      flags.zero           = 1'b1;
      flags.precision_lost = 1'b1;
    end
    else
    begin
      flags.precision_lost = frac_lost;
    end
  end

endmodule

// ==== hdl/fixflo_unit.sv ====
// fixflo_unit
// 16-bit arithmetic unit: 8.8 fixed add and multiply, binary16 multiply;
// samples a request on in_valid and presents the result two cycles later

`timescale 1ns/1ns

module fixflo_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  fixflo_pkg::op_e    op,
  input  fixflo_pkg::word_t  a,
  input  fixflo_pkg::word_t  b,
  output logic               out_valid,
  output fixflo_pkg::word_t  result,
  output fixflo_pkg::flags_t flags
);
  import fixflo_pkg::*;

  fix_req_t        req;
  logic            req_valid;
  logic [WORD_W:0] add_full;  // carry in the msb
  word_t           mul_result;
  word_t           flt_result;
  word_t           sel_result;
  flags_t          mul_flags;
  flags_t          flt_flags;
  flags_t          sel_flags;

  // request sampling stage
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      req_valid <= 1'b0;
    else
      req_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
      req <= '{op: op, a: a, b: b};
  end

  fixed_multiplier u_fixed_mul (
    .a      (req.a),
    .b      (req.b),
    .result (mul_result),
    .flags  (mul_flags)
  );

  half_multiplier u_half_mul (
    .a      (req.a),
    .b      (req.b),
    .result (flt_result),
    .flags  (flt_flags)
  );

  assign add_full = {1'b0, req.a} + {1'b0, req.b};

  always_comb
  begin
    sel_result = '0;
    sel_flags  = '0;
    case (req.op)
      OP_FIX_ADD:
      begin
        sel_result         = add_full[WORD_W-1:0];
        sel_flags.overflow = add_full[WORD_W];
      end
      OP_FIX_MUL:
      begin
        sel_result = mul_result;
        sel_flags  = mul_flags;
      end
      OP_FLT_MUL:
      begin
        sel_result = flt_result;
        sel_flags  = flt_flags;
      end
      default:
      begin
        sel_result = '0;  // unused code gives a clean zero
        sel_flags  = '0;
      end
    endcase
  end

  // result stage, loaded only for a sampled request
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end
    else
    begin
      out_valid <= req_valid;
      if (req_valid)
      begin
        result <= sel_result;
        flags  <= sel_flags;
      end
    end
  end

endmodule

// ==== tests/fixflo_checks.svh ====
// fixflo reference model and compare tasks
// included inside the testbench module and typed by the package

function automatic logic [31:0] fix_product(input word_t x, input word_t y);
  return {16'h0000, x} * {16'h0000, y};  // 8.8 times 8.8 gives 16.16
endfunction

task automatic model_flt_mul(input word_t x, input word_t y,
                             output word_t r, output flags_t f);
  int          ex;
  int          ey;
  int          e;
  logic [21:0] p;
  logic [9:0]  frac;
  logic        lost;
  logic        s;
  logic        x_zero;
  logic        x_inf;
  logic        x_nan;
  logic        y_zero;
  logic        y_inf;
  logic        y_nan;
  ex     = int'(x[14:10]);
  ey     = int'(y[14:10]);
  s      = x[15] ^ y[15];
  x_zero = (ex == 0);  // subnormals count as zero
  y_zero = (ey == 0);
  x_inf  = (ex == 31) && (x[9:0] == 10'h000);
  y_inf  = (ey == 31) && (y[9:0] == 10'h000);
  x_nan  = (ex == 31) && (x[9:0] != 10'h000);
  y_nan  = (ey == 31) && (y[9:0] != 10'h000);
  p      = {11'h000, 1'b1, x[9:0]} * {11'h000, 1'b1, y[9:0]};
  e      = ex + ey - 15;
  if (p[21])
  begin
    e    = e + 1;
    frac = p[20:11];
    lost = |p[10:0];
  end
  else
  begin
    frac = p[19:10];
    lost = |p[9:0];
  end
  f = '0;
  r = {s, e[4:0], frac};
  if (x_nan || y_nan || (x_inf && y_zero) || (x_zero && y_inf))
  begin
    r     = QNAN;
    f.nan = 1'b1;
  end
  else if (x_inf || y_inf)
  begin
    r          = {s, 5'h1f, 10'h000};
    f.overflow = 1'b1;
  end
  else if (x_zero || y_zero)
  begin
    r      = {s, 15'h0000};
    f.zero = 1'b1;
  end
  else if (e >= 31)
  begin
    r = {s, 5'h1f, 10'h000};  // too large
    f.overflow       = 1'b1;
    f.precision_lost = 1'b1;
  end
  else if (e < 1)
  begin
    r = {s, 15'h0000};
    f.zero           = 1'b1;
    f.precision_lost = 1'b1;
  end
  else
    f.precision_lost = lost;
endtask

task automatic model_op(input op_e o, input word_t x, input word_t y,
                        output word_t r, output flags_t f);
  int          sum;
  logic [31:0] p;
  f = '0;
  r = '0;
  case (o)
    OP_FIX_ADD:
    begin
      sum        = int'(x) + int'(y);
      r          = word_t'(sum);
      f.overflow = (sum >= 65536);  // sum past the 8.8 range
    end
    OP_FIX_MUL:
    begin
      p                = fix_product(x, y);
      r                = p[23:8];
      f.overflow       = |p[31:24];
      f.precision_lost = |p[7:0];
    end
    OP_FLT_MUL:
      model_flt_mul(x, y, r, f);
    default:
      r = '0;
  endcase
endtask

task automatic check_result(input word_t got, input word_t expected, input string what);
  if (got !== expected)
  begin
    mismatches++;
    $display("MISMATCH at %0t: %s result 0x%04h, expected 0x%04h",
             $time, what, got, expected);
  end
endtask

task automatic check_flags(input flags_t got, input flags_t expected, input string what);
  if (got !== expected)
  begin
    mismatches++;
    $display("MISMATCH at %0t: %s flags %b, expected %b (ovf zero nan lost)",
             $time, what, got, expected);
  end
endtask

// ==== tests/fixflo_tb.sv ====
// fixflo_tb
// directed and seeded random tests of the fixflo arithmetic unit,
// with a monitor that checks every out_valid against a queue of expectations

`timescale 1ns/1ns

module fixflo_tb;
  import fixflo_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  logic   clk;
  logic   rst_n;
  logic   in_valid;
  op_e    op;
  word_t  a;
  word_t  b;
  logic   out_valid;
  word_t  result;
  flags_t flags;

  int     seed = 13356;
  int     mismatches = 0;
  int     other_errors = 0;
  int     edge_cnt = 0;  // rising edges seen so far

  word_t  res_q[$];
  flags_t flg_q[$];
  int     edge_q[$];
  string  tag_q[$];
  int     mon_edge;
  string  mon_tag;

  `include "fixflo_checks.svh"

  fixflo_unit u_fixflo_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    edge_cnt <= edge_cnt + 1;
    if (edge_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // sampled mid cycle away from the clock edge
  always @(negedge clk)
  begin
    if (out_valid === 1'b1)
    begin
      if (res_q.size() == 0)
      begin
        other_errors++;
        $display("out_valid rose at %0t with no request pending", $time);
      end
      else
      begin
        mon_edge = edge_q.pop_front();
        mon_tag  = tag_q.pop_front();
        check_result(result, res_q.pop_front(), mon_tag);
        check_flags(flags, flg_q.pop_front(), mon_tag);
        if (edge_cnt != mon_edge)
        begin
          other_errors++;
          $display("%s response came at edge %0d instead of edge %0d", mon_tag,
                   edge_cnt, mon_edge);
        end
      end
    end
    else if (out_valid !== 1'b0)
    begin
      other_errors++;
      $display("out_valid is unknown at %0t", $time);
    end
  end

  function automatic word_t rand_word();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[15:0];
  endfunction

  function automatic word_t rand_normal();
    logic [31:0] rnd;
    logic [4:0]  e;
    rnd = $random(seed);
    e   = 5'(rnd[20:16] % 5'd30) + 5'd1;  // 1 to 30
    return {rnd[31], e, rnd[9:0]};
  endfunction

  // one request on the next edge with its response due two edges later
  task automatic send_req(input op_e o, input word_t x, input word_t y,
                          input word_t r, input flags_t f, input string tag);
    @(posedge clk);
    in_valid <= 1'b1;
    op       <= o;
    a        <= x;
    b        <= y;
    res_q.push_back(r);
    flg_q.push_back(f);
    edge_q.push_back(edge_cnt + 3);
    tag_q.push_back(tag);
  endtask

  task automatic send_model(input op_e o, input word_t x, input word_t y, input string tag);
    word_t  r;
    flags_t f;
    model_op(o, x, y, r, f);
    send_req(o, x, y, r, f, tag);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    while (res_q.size() != 0)
      @(posedge clk);
  endtask

  task automatic apply_reset();
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_result(result, word_t'(0), "reset");
    check_flags(flags, flags_t'(4'b0000), "reset");
    @(posedge clk);
    rst_n <= 1'b1;  // released on the 8th edge
    idle(2);
  endtask

  task automatic test_fix_add();
    send_req(OP_FIX_ADD, 16'hFF00, 16'h0200, 16'h0100, 4'b1000, "fix add carry");
    send_req(OP_FIX_ADD, 16'h0180, 16'h0080, 16'h0200, 4'b0000, "fix add");
    idle(1);
    repeat (200)
    begin
      send_model(OP_FIX_ADD, rand_word(), rand_word(), "fix add random");
      idle(1);
    end
    drain();
  endtask

  task automatic test_fix_mul();
    send_req(OP_FIX_MUL, 16'h0200, 16'h0380, 16'h0700, 4'b0000, "fix mul 2*3.5");
    send_req(OP_FIX_MUL, 16'h1000, 16'h1000, 16'h0000, 4'b1000, "fix mul overflow");
    send_req(OP_FIX_MUL, 16'h0001, 16'h0001, 16'h0000, 4'b0001, "fix mul tiny");
    idle(1);
    repeat (200)
    begin
      send_model(OP_FIX_MUL, rand_word(), rand_word(), "fix mul random");
      idle(1);
    end
    drain();
  endtask

  task automatic test_flt_mul();
    send_req(OP_FLT_MUL, 16'h3E00, 16'h3E00, 16'h4080, 4'b0000, "flt 1.5*1.5");
    send_req(OP_FLT_MUL, 16'hC000, 16'h3800, 16'hBC00, 4'b0000, "flt -2*0.5");
    idle(1);
    repeat (300)
    begin
      send_model(OP_FLT_MUL, rand_normal(), rand_normal(), "flt mul random");
      idle(1);
    end
    drain();
  endtask

  task automatic test_flt_special();
    send_req(OP_FLT_MUL, 16'h7E01, 16'h3C00, QNAN, 4'b0010, "flt nan operand");
    send_req(OP_FLT_MUL, 16'h7C00, 16'h0000, QNAN, 4'b0010, "flt inf*0");
    send_req(OP_FLT_MUL, 16'hFC00, 16'h4000, 16'hFC00, 4'b1000, "flt -inf*2");
    send_req(OP_FLT_MUL, 16'h8000, 16'h4000, 16'h8000, 4'b0100, "flt -0*2");
    send_req(OP_FLT_MUL, 16'h0001, 16'h3C00, 16'h0000, 4'b0100, "flt subnormal");
    send_req(OP_FLT_MUL, 16'h7800, 16'h7800, 16'h7C00, 4'b1001, "flt exp overflow");
    send_req(OP_FLT_MUL, 16'h0400, 16'h0400, 16'h0000, 4'b0101, "flt underflow");
    send_req(OP_FLT_MUL, 16'h8400, 16'h0400, 16'h8000, 4'b0101, "flt -underflow");
    idle(1);
    drain();
  endtask

  // mixed ops on consecutive edges
  task automatic test_back_to_back();
    op_e ops[3];
    ops = '{OP_FIX_ADD, OP_FIX_MUL, OP_FLT_MUL};
    repeat (60)
      send_model(ops[{$random(seed)} % 3], rand_word(), rand_word(), "back to back");
    idle(6);
    drain();
  endtask

  initial
  begin
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    op       <= OP_FIX_ADD;
    a        <= '0;
    b        <= '0;
    apply_reset();
    test_fix_add();
    test_fix_mul();
    test_flt_mul();
    test_flt_special();
    test_back_to_back();
    idle(4);  // out_valid must stay low here
    $display("closing report: %0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== fixflo.f ====
+incdir+tests
hdl/fixflo_pkg.sv
hdl/fixed_multiplier.sv
hdl/half_decoder.sv
hdl/half_multiplier.sv
hdl/fixflo_unit.sv
tests/fixflo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the fixflo testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module fixflo_tb -f fixflo.f -o fixflo_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/fixflo_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
